//--- force_wb_pkg.sv
`default_nettype none

package force_wb_pkg;

	// Particle addressing
	localparam int PARTICLE_ID_WIDTH = 7;
	// One cache entry per particle id
	localparam int NUM_PARTICLES = 1 << PARTICLE_ID_WIDTH;

	// Signed fixed-point force component, adds wrap on overflow
	localparam int COMP_WIDTH = 32;

	// Adder pipeline depth, counted from cache read data to write port
	localparam int ACC_LATENCY = 3;
	// Issue slots an id stays blocked after it is issued
	localparam int INFLIGHT_DEPTH = ACC_LATENCY + 3;

	typedef logic [PARTICLE_ID_WIDTH-1:0] particle_id_t;

	// x sits in the top bits
	typedef struct packed {
		logic signed [COMP_WIDTH-1:0] x;
		logic signed [COMP_WIDTH-1:0] y;
		logic signed [COMP_WIDTH-1:0] z;
	} force_vec_t;

	// One partial force, as it arrives and as it is parked
	typedef struct packed {
		particle_id_t id;
		force_vec_t   force_val;
	} force_entry_t;

	// Motion-update read result
	typedef struct packed {
		logic         valid;
		particle_id_t id;
		force_vec_t   force_val;
	} force_result_t;

endpackage

`default_nettype wire

//--- force_input_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module force_input_buffer import force_wb_pkg::*;
#(
	parameter int BUFFER_DEPTH = 16
)
(
	input  logic         clk,
	input  logic         rst,
	input  logic         push,
	input  force_entry_t push_entry,
	input  logic         pop,
	input  logic         taken,
	output force_entry_t head,
	output logic         head_valid,
	output logic         empty
);

	localparam int PTR_WIDTH = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(BUFFER_DEPTH + 1);
	localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(BUFFER_DEPTH - 1);
	localparam logic [CNT_WIDTH-1:0] FULL_COUNT = CNT_WIDTH'(BUFFER_DEPTH);

	force_entry_t mem [BUFFER_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;

	// Pointers wrap explicitly so any depth works
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			head_valid <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Head stays valid until the controller issues it
			if (pop)
				head_valid <= 1'b1;
			else if (taken)
				head_valid <= 1'b0;
		end
	end

	// Storage and registered head
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_entry;
		if (pop)
			head <= mem[rd_ptr];
	end

	// A parked entry waiting in the head register still counts as pending
	assign empty = (count == '0) && !head_valid;

	// Overflow is a usage error since nothing pushes back upstream
	assert property (@(posedge clk) disable iff (rst) push |-> count != FULL_COUNT);
	assert property (@(posedge clk) disable iff (rst) pop |-> count != '0);

endmodule

`default_nettype wire

//--- force_cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module force_cache_ram import force_wb_pkg::*;
(
	input  logic         clk,
	input  particle_id_t raddr,
	input  logic         we,
	input  particle_id_t waddr,
	input  force_vec_t   wdata,
	output force_vec_t   rdata
);

	// One accumulated force per particle
	// Contents are undefined until a read sweep clears them
	force_vec_t mem [NUM_PARTICLES];

	// Write port, driven by the accumulator
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read, old data on a same-address collision
	// The hazard tracker keeps accumulation from hitting that case
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- force_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module force_accumulator import force_wb_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         acc_valid,
	input  logic         acc_clear,
	input  particle_id_t acc_id,
	input  force_vec_t   acc_in,
	input  force_vec_t   cache_rdata,
	output logic         cache_we,
	output particle_id_t cache_waddr,
	output force_vec_t   cache_wdata
);

	// Issued force, held one cycle until the cache read data arrives
	force_vec_t   in_d;
	logic         valid_d;
	logic         clear_d;
	particle_id_t id_d;

	// Sum pipeline with its control side-band
	force_vec_t             sum_pipe [ACC_LATENCY];
	particle_id_t           id_pipe [ACC_LATENCY];
	logic [ACC_LATENCY-1:0] valid_pipe;
	logic [ACC_LATENCY-1:0] clear_pipe;

	// Lane-wise add, each lane wraps at COMP_WIDTH
	function automatic force_vec_t add_lanes(input force_vec_t a, input force_vec_t b);
		force_vec_t s;
		s.x = a.x + b.x;
		s.y = a.y + b.y;
		s.z = a.z + b.z;
		return s;
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_d <= 1'b0;
			clear_d <= 1'b0;
			valid_pipe <= '0;
			clear_pipe <= '0;
		end
		else
		begin
			valid_d <= acc_valid;
			clear_d <= acc_clear;
			valid_pipe <= {valid_pipe[ACC_LATENCY-2:0], valid_d};
			clear_pipe <= {clear_pipe[ACC_LATENCY-2:0], clear_d};
		end
	end

	// Add in the first stage, later stages give the adder room to retime
	always_ff @(posedge clk)
	begin
		in_d <= acc_in;
		id_d <= acc_id;
		sum_pipe[0] <= add_lanes(cache_rdata, in_d);
		id_pipe[0] <= id_d;
		for (int i = 1; i < ACC_LATENCY; i++)
		begin
			sum_pipe[i] <= sum_pipe[i-1];
			id_pipe[i] <= id_pipe[i-1];
		end
	end

	assign cache_we = valid_pipe[ACC_LATENCY-1];
	assign cache_waddr = id_pipe[ACC_LATENCY-1];
	// Clear after a motion-update read writes zero
	assign cache_wdata = clear_pipe[ACC_LATENCY-1] ? '0 : sum_pipe[ACC_LATENCY-1];

endmodule

`default_nettype wire

//--- force_hazard_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module force_hazard_tracker import force_wb_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         issue_valid,
	input  particle_id_t issue_id,
	input  particle_id_t cand_a,
	input  particle_id_t cand_b,
	output logic         busy_a,
	output logic         busy_b
);

	// Slot 0 holds the most recent issue, shifted every cycle
	logic [INFLIGHT_DEPTH-1:0] slot_valid;
	particle_id_t              slot_id [INFLIGHT_DEPTH];

	// Empty slots carry no valid bit, so id 0 is never blocked by them
	always_ff @(posedge clk)
	begin
		if (rst)
			slot_valid <= '0;
		else
			slot_valid <= {slot_valid[INFLIGHT_DEPTH-2:0], issue_valid};
	end

	always_ff @(posedge clk)
	begin
		slot_id[0] <= issue_id;
		for (int i = 1; i < INFLIGHT_DEPTH; i++)
			slot_id[i] <= slot_id[i-1];
	end

	// Candidate blocked while its id is still between issue and write-back
	always_comb
	begin
		busy_a = 1'b0;
		busy_b = 1'b0;
		for (int i = 0; i < INFLIGHT_DEPTH; i++)
		begin
			if (slot_valid[i] && (slot_id[i] == cand_a))
				busy_a = 1'b1;
			if (slot_valid[i] && (slot_id[i] == cand_b))
				busy_b = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- force_wb_controller.sv
`timescale 1ns/1ps
`default_nettype none

module force_wb_controller import force_wb_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          wr_enable,
	input  force_entry_t  wr_entry,
	input  logic          rd_enable,
	input  particle_id_t  rd_id,
	input  force_entry_t  buf_head,
	input  logic          buf_head_valid,
	input  logic          buf_empty,
	input  force_vec_t    cache_rdata,
	output logic          buf_push,
	output force_entry_t  buf_push_entry,
	output logic          buf_pop,
	output logic          buf_taken,
	output particle_id_t  cache_raddr,
	output force_vec_t    acc_in,
	output logic          acc_valid,
	output logic          acc_clear,
	output particle_id_t  acc_id,
	output force_result_t rd_result
);

	// Fresh input, delayed to line up with the buffer head
	logic         wr_valid_d;
	force_entry_t wr_entry_d;

	// Read strobe delay line, covers address and cache read latency
	logic         rd_enable_d1;
	logic         rd_enable_d2;
	particle_id_t rd_id_d1;
	particle_id_t rd_id_d2;
	logic         rd_busy;

	// Hazard flags for the two issue candidates
	logic fresh_busy;
	logic head_busy;

	// Issue decision for this cycle
	logic         issue_valid;
	logic         issue_clear;
	particle_id_t issue_id;
	force_vec_t   issue_force;
	particle_id_t issue_id_q;

	// Registered read result
	logic         rd_valid_q;
	particle_id_t rd_id_q;
	force_vec_t   rd_force_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_valid_d <= 1'b0;
			rd_enable_d1 <= 1'b0;
			rd_enable_d2 <= 1'b0;
		end
		else
		begin
			wr_valid_d <= wr_enable;
			rd_enable_d1 <= rd_enable;
			rd_enable_d2 <= rd_enable_d1;
		end
	end

	always_ff @(posedge clk)
	begin
		wr_entry_d <= wr_entry;
		rd_id_d1 <= rd_id;
		rd_id_d2 <= rd_id_d1;
	end

	// Read owns the cache for three cycles
	assign rd_busy = rd_enable | rd_enable_d1 | rd_enable_d2;

	force_hazard_tracker hazard_tracker_inst (
		.clk        (clk),
		.rst        (rst),
		.issue_valid(issue_valid),
		.issue_id   (issue_id),
		.cand_a     (wr_entry_d.id),
		.cand_b     (buf_head.id),
		.busy_a     (fresh_busy),
		.busy_b     (head_busy)
	);

	// Priority: read clear, then conflict-free fresh input, then buffer head
	always_comb
	begin
		issue_valid = 1'b0;
		issue_clear = 1'b0;
		issue_id = wr_entry_d.id;
		issue_force = wr_entry_d.force_val;
		buf_taken = 1'b0;
		if (rd_busy)
		begin
			// Clear goes through the adder so it also enters the tracker
			issue_valid = rd_enable;
			issue_clear = rd_enable;
			issue_id = rd_id;
			issue_force = '0;
		end
		else if (wr_valid_d && !fresh_busy)
		begin
			issue_valid = 1'b1;
		end
		else if (buf_head_valid && !head_busy)
		begin
			issue_valid = 1'b1;
			issue_id = buf_head.id;
			issue_force = buf_head.force_val;
			buf_taken = 1'b1;
		end
	end

	// Park fresh input that cannot issue this cycle
	assign buf_push = wr_valid_d && (rd_busy || fresh_busy);
	assign buf_push_entry = wr_entry_d;
	// One entry in the head register at a time
	assign buf_pop = !buf_empty && !buf_head_valid && !rd_busy;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc_valid <= 1'b0;
			acc_clear <= 1'b0;
			rd_valid_q <= 1'b0;
		end
		else
		begin
			acc_valid <= issue_valid;
			acc_clear <= issue_clear;
			rd_valid_q <= rd_enable_d2;
		end
	end

	always_ff @(posedge clk)
	begin
		issue_id_q <= issue_id;
		acc_in <= issue_force;
		rd_id_q <= rd_id_d2;
		rd_force_q <= cache_rdata;
	end

	// Cache is read at the issued id, the adder writes back there
	assign cache_raddr = issue_id_q;
	assign acc_id = issue_id_q;

	assign rd_result = '{valid: rd_valid_q, id: rd_id_q, force_val: rd_force_q};

	// Reads and accumulation are separate phases
	assert property (@(posedge clk) disable iff (rst)
		rd_enable |-> !wr_enable && !wr_valid_d && buf_empty);

endmodule

`default_nettype wire

//--- force_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module force_wb_top import force_wb_pkg::*;
#(
	parameter int BUFFER_DEPTH = 16
)
(
	input  logic          clk,
	input  logic          rst,
	input  logic          wr_enable,
	input  force_entry_t  wr_entry,
	input  logic          rd_enable,
	input  particle_id_t  rd_id,
	output force_result_t rd_result,
	output logic          buffer_empty
);

	// Controller to input buffer
	logic         buf_push;
	force_entry_t buf_push_entry;
	logic         buf_pop;
	logic         buf_taken;
	force_entry_t buf_head;
	logic         buf_head_valid;

	// Cache read side and adder inputs
	particle_id_t cache_raddr;
	force_vec_t   cache_rdata;
	force_vec_t   acc_in;
	logic         acc_valid;
	logic         acc_clear;
	particle_id_t acc_id;

	// Write-back from the adder
	logic         cache_we;
	particle_id_t cache_waddr;
	force_vec_t   cache_wdata;

	force_wb_controller controller_inst (
		.clk           (clk),
		.rst           (rst),
		.wr_enable     (wr_enable),
		.wr_entry      (wr_entry),
		.rd_enable     (rd_enable),
		.rd_id         (rd_id),
		.buf_head      (buf_head),
		.buf_head_valid(buf_head_valid),
		.buf_empty     (buffer_empty),
		.cache_rdata   (cache_rdata),
		.buf_push      (buf_push),
		.buf_push_entry(buf_push_entry),
		.buf_pop       (buf_pop),
		.buf_taken     (buf_taken),
		.cache_raddr   (cache_raddr),
		.acc_in        (acc_in),
		.acc_valid     (acc_valid),
		.acc_clear     (acc_clear),
		.acc_id        (acc_id),
		.rd_result     (rd_result)
	);

	force_input_buffer #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) input_buffer_inst (
		.clk       (clk),
		.rst       (rst),
		.push      (buf_push),
		.push_entry(buf_push_entry),
		.pop       (buf_pop),
		.taken     (buf_taken),
		.head      (buf_head),
		.head_valid(buf_head_valid),
		.empty     (buffer_empty)
	);

	force_cache_ram cache_ram_inst (
		.clk  (clk),
		.raddr(cache_raddr),
		.we   (cache_we),
		.waddr(cache_waddr),
		.wdata(cache_wdata),
		.rdata(cache_rdata)
	);

	force_accumulator accumulator_inst (
		.clk        (clk),
		.rst        (rst),
		.acc_valid  (acc_valid),
		.acc_clear  (acc_clear),
		.acc_id     (acc_id),
		.acc_in     (acc_in),
		.cache_rdata(cache_rdata),
		.cache_we   (cache_we),
		.cache_waddr(cache_waddr),
		.cache_wdata(cache_wdata)
	);

endmodule

`default_nettype wire

//--- tb_force_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_force_wb import force_wb_pkg::*;
();

	localparam int BUFFER_DEPTH = 16;
	// Settle time after the buffer reports empty
	localparam int DRAIN_CYCLES = 10;
	localparam logic [31:0] LCG_SEED = 32'd92;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE, OP_DRAIN} op_kind_t;

	// One table row, force_val is write data or the expected read data
	typedef struct packed {
		op_kind_t     kind;
		particle_id_t id;
		force_vec_t   force_val;
		logic         exp_known;
		logic [7:0]   cycles;
	} op_t;

	// Read result the monitor waits for
	typedef struct packed {
		logic [31:0]  due;
		particle_id_t id;
		force_vec_t   force_val;
		logic         known;
	} exp_t;

	logic          clk;
	logic          rst;
	logic          wr_enable;
	force_entry_t  wr_entry;
	logic          rd_enable;
	particle_id_t  rd_id;
	force_result_t rd_result;
	logic          buffer_empty;

	op_t         ops [$];
	exp_t        exp_q [$];
	exp_t        mon_exp;
	force_vec_t  model [NUM_PARTICLES];
	logic [31:0] lcg_state;
	logic [31:0] cycle_cnt = '0;
	int          table_len = 0;

	force_wb_top #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) force_wb_top_inst (
		.clk         (clk),
		.rst         (rst),
		.wr_enable   (wr_enable),
		.wr_entry    (wr_entry),
		.rd_enable   (rd_enable),
		.rd_id       (rd_id),
		.rd_result   (rd_result),
		.buffer_empty(buffer_empty)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 32'd1;

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic force_vec_t rand_force();
		force_vec_t f;
		f.x = rand_word();
		f.y = rand_word();
		f.z = rand_word();
		return f;
	endfunction

	// Reference adder, carry out of bit 31 is dropped
	function automatic logic [COMP_WIDTH-1:0] wrap_add(input logic [COMP_WIDTH-1:0] a,
		input logic [COMP_WIDTH-1:0] b);
		logic [COMP_WIDTH:0] full;
		full = {1'b0, a} + {1'b0, b};
		return full[COMP_WIDTH-1:0];
	endfunction

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h (cycle %0d)",
				name, actual, expected, cycle_cnt);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_id(input string name, input particle_id_t actual,
		input particle_id_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h (cycle %0d)",
				name, actual, expected, cycle_cnt);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_force(input string name, input force_vec_t actual,
		input force_vec_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h (cycle %0d)",
				name, actual, expected, cycle_cnt);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Table building, the model is updated as rows are added
	task automatic add_write(input particle_id_t id, input force_vec_t f);
		op_t op;
		op = '0;
		op.kind = OP_WRITE;
		op.id = id;
		op.force_val = f;
		ops.push_back(op);
		model[id].x = wrap_add(model[id].x, f.x);
		model[id].y = wrap_add(model[id].y, f.y);
		model[id].z = wrap_add(model[id].z, f.z);
	endtask

	// A read returns the sum, then the entry is zero
	task automatic add_read(input particle_id_t id, input logic known);
		op_t op;
		op = '0;
		op.kind = OP_READ;
		op.id = id;
		op.force_val = model[id];
		op.exp_known = known;
		ops.push_back(op);
		model[id] = '0;
	endtask

	task automatic add_idle(input logic [7:0] n);
		op_t op;
		op = '0;
		op.kind = OP_IDLE;
		op.cycles = n;
		ops.push_back(op);
	endtask

	task automatic add_drain();
		op_t op;
		op = '0;
		op.kind = OP_DRAIN;
		ops.push_back(op);
	endtask

	task automatic build_table();
		force_vec_t   f;
		particle_id_t distinct_ids [5];
		particle_id_t hot_ids [5];
		logic [31:0]  w;
		int           sel;
		distinct_ids = '{7'd5, 7'd17, 7'd42, 7'd99, 7'd127};
		hot_ids = '{7'd0, 7'd1, 7'd2, 7'd64, 7'd127};
		// Contents are unknown after reset, first sweep only clears
		for (int i = 0; i < NUM_PARTICLES; i++)
			add_read(particle_id_t'(i), 1'b0);
		add_idle(8'd8);
		for (int i = 0; i < NUM_PARTICLES; i++)
			add_read(particle_id_t'(i), 1'b1);
		add_idle(8'd8);
		// Single writes to distinct ids
		for (int i = 0; i < 5; i++)
		begin
			add_write(distinct_ids[i], rand_force());
			add_idle(8'd1);
		end
		add_drain();
		for (int i = 0; i < 5; i++)
			add_read(distinct_ids[i], 1'b1);
		add_idle(8'd8);
		// Same id back to back, first rows overflow every lane
		f.x = 32'h7fff_ffff;
		f.y = 32'h8000_0000;
		f.z = 32'hffff_ffff;
		add_write(7'd33, f);
		f.x = 32'h0000_0001;
		f.y = 32'hffff_ffff;
		f.z = 32'h0000_0001;
		add_write(7'd33, f);
		f.x = 32'h7fff_ffff;
		f.y = 32'h8000_0000;
		f.z = 32'h8000_0000;
		add_write(7'd33, f);
		for (int i = 0; i < 7; i++)
			add_write(7'd33, rand_force());
		add_drain();
		add_read(7'd33, 1'b1);
		add_idle(8'd8);
		// Second read must see the cleared entry
		add_read(7'd33, 1'b1);
		add_idle(8'd8);
		// Particle 0 burst
		for (int i = 0; i < 6; i++)
			add_write(7'd0, rand_force());
		add_drain();
		add_read(7'd0, 1'b1);
		add_idle(8'd8);
		// Random mix over a few ids, groups stay well below buffer depth
		for (int g = 0; g < 4; g++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				sel = int'(rand_word() % 32'd5);
				add_write(hot_ids[sel], rand_force());
				w = rand_word();
				if (w[17])
					add_idle(8'd1);
			end
			add_drain();
		end
		for (int i = 0; i < 5; i++)
			add_read(hot_ids[i], 1'b1);
		add_idle(8'd8);
		for (int i = 0; i < 5; i++)
			add_read(hot_ids[i], 1'b1);
		add_idle(8'd8);
	endtask

	task automatic drive_idle();
		@(posedge clk);
		wr_enable <= 1'b0;
		rd_enable <= 1'b0;
	endtask

	// Wait for parked writes to issue and for the adder to write back
	task automatic wait_drain();
		repeat (3) drive_idle();
		@(negedge clk);
		while (buffer_empty !== 1'b1)
			@(negedge clk);
		repeat (DRAIN_CYCLES) drive_idle();
	endtask

	task automatic apply_op(input op_t op);
		exp_t e;
		case (op.kind)
			OP_WRITE:
			begin
				@(posedge clk);
				wr_enable <= 1'b1;
				wr_entry <= '{id: op.id, force_val: op.force_val};
				rd_enable <= 1'b0;
			end
			OP_READ:
			begin
				@(posedge clk);
				wr_enable <= 1'b0;
				rd_enable <= 1'b1;
				rd_id <= op.id;
				// cycle_cnt still holds the count from before this edge
				e.due = cycle_cnt + 32'd4;
				e.id = op.id;
				e.force_val = op.force_val;
				e.known = op.exp_known;
				exp_q.push_back(e);
			end
			OP_IDLE:
				repeat (op.cycles) drive_idle();
			default:
				wait_drain();
		endcase
	endtask

	// Result monitor, valid must be high exactly in the expected cycle
	always @(negedge clk)
	begin
		if (rst === 1'b0)
		begin
			if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt)
			begin
				mon_exp = exp_q.pop_front();
				check_bit("rd_result.valid", rd_result.valid, 1'b1);
				check_id("rd_result.id", rd_result.id, mon_exp.id);
				if (mon_exp.known)
					check_force("rd_result.force_val", rd_result.force_val, mon_exp.force_val);
			end
			else
				check_bit("rd_result.valid", rd_result.valid, 1'b0);
		end
	end

	initial
	begin
		wait (table_len > 0);
		repeat (table_len * 20 + 2000) @(posedge clk);
		$display("Watchdog expired before the test table finished");
		$display("tests failed");
		$fatal(1, "watchdog timeout");
	end

	initial
	begin
		rst = 1'b1;
		wr_enable = 1'b0;
		wr_entry = '0;
		rd_enable = 1'b0;
		rd_id = '0;
		lcg_state = LCG_SEED;
		foreach (model[i])
			model[i] = '0;
		build_table();
		table_len = ops.size();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit("buffer_empty", buffer_empty, 1'b1);
		check_bit("rd_result.valid", rd_result.valid, 1'b0);
		foreach (ops[i])
			apply_op(ops[i]);
		repeat (DRAIN_CYCLES) drive_idle();
		@(negedge clk);
		if (exp_q.size() != 0)
		begin
			$display("Some expected read results never appeared (%0d left)", exp_q.size());
			$display("tests failed");
			$fatal(1, "missing read results");
		end
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
force_wb_pkg.sv
force_input_buffer.sv
force_cache_ram.sv
force_accumulator.sv
force_hazard_tracker.sv
force_wb_controller.sv
force_wb_top.sv
tb_force_wb.sv

//--- Makefile
# Verilator flow for the force write-back testbench

VERILATOR ?= verilator
TOP       ?= tb_force_wb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

# The log decides the result, not the simulator exit status
sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
